// ==== verilog/app_soc_defines.svh ====
/*
  Memory subsystem constants: RAM size, trap word and control block identity
*/
`ifndef APP_SOC_DEFINES_SVH
`define APP_SOC_DEFINES_SVH

// RAM word address width, 1024 words
`define RAM_ADDR_BITS 10
`define RAM_WORDS (1 << `RAM_ADDR_BITS)

// Returned instead of the fetched word when a trap is forced
`define ILLEGAL_INSTRUCTION 32'h0000_0000

// Identity word of the control block, "app_" in ASCII
`define CTRL_NAME0 32'h6170_705f

`endif

// ==== verilog/bus_pkg.sv ====
/*
  Bus types: master request/response, address views, core-side port structs
*/
`include "app_soc_defines.svh"

package bus_pkg;

  // ----------------------------------------------------------------------
  // Address views
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [1:0]  area;
    logic [5:0]  core;
    logic [23:0] offset;
  } mmio_addr_t;

  typedef struct packed {
    logic [1:0]  area;
    logic [27:0] word;
    logic [1:0]  byte_sel;
  } mem_addr_t;

  // Same 32-bit address, decoded as MMIO or as plain memory
  typedef union packed {
    mmio_addr_t mmio;
    mem_addr_t  mem;
  } addr_u;

  // ----------------------------------------------------------------------
  // Master side
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic        valid;
    logic        instr;
    addr_u       addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  // ----------------------------------------------------------------------
  // Core side
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic        cs;
    logic [3:0]  we;
    logic [7:0]  address;
    logic [31:0] write_data;
  } core_req_t;

  // RAM needs the full word index on top of the core request
  typedef struct packed {
    core_req_t                 core;
    logic [`RAM_ADDR_BITS-1:0] word;
  } ram_req_t;

  typedef struct packed {
    logic [31:0] read_data;
    logic        ready;
  } core_rsp_t;

endpackage

// ==== verilog/core_pkg.sv ====
/*
  Address map: area and core prefixes, register offsets of the MMIO cores
*/
package core_pkg;

  // Top two address bits
  typedef enum logic [1:0] {
    AREA_ROM      = 2'h0,
    AREA_RAM      = 2'h1,
    AREA_RESERVED = 2'h2,
    AREA_MMIO     = 2'h3
  } area_e;

  // Core select inside the MMIO area
  typedef enum logic [5:0] {
    CORE_TIMER = 6'h01,
    CORE_CTRL  = 6'h3f
  } core_e;

  // Timer registers, word offsets
  localparam logic [7:0] TIMER_CTRL      = 8'h08;
  localparam logic [7:0] TIMER_STATUS    = 8'h09;
  localparam logic [7:0] TIMER_PRESCALER = 8'h0a;
  localparam logic [7:0] TIMER_INITIAL   = 8'h0b;
  localparam logic [7:0] TIMER_COUNT     = 8'h0c;

  // Control block registers
  localparam logic [7:0] CTRL_NAME     = 8'h00;
  localparam logic [7:0] CTRL_APP_MODE = 8'h08;
  localparam logic [7:0] CTRL_LED      = 8'h09;

endpackage

// ==== verilog/mem_decoder.sv ====
/*
  Memory decoder: splits master requests over the cores and registers
  the selected response, with a forced trap override
*/
`include "app_soc_defines.svh"

module mem_decoder (
  input  logic               clk,
  input  logic               reset_n,
  input  bus_pkg::mem_req_t  mem_req,
  output bus_pkg::mem_rsp_t  mem_rsp,
  input  logic               force_trap,
  output bus_pkg::ram_req_t  ram_req,
  output bus_pkg::core_req_t timer_req,
  output bus_pkg::core_req_t ctrl_req,
  input  bus_pkg::core_rsp_t ram_rsp,
  input  bus_pkg::core_rsp_t timer_rsp,
  input  bus_pkg::core_rsp_t ctrl_rsp
);

  logic [31:0] rdata_reg;
  logic [31:0] rdata_new;
  logic        ready_reg;
  logic        ready_new;
  logic        access;

  // No new select while the previous answer is on the bus
  assign access = mem_req.valid && !ready_reg;

  assign mem_rsp.ready = ready_reg;
  assign mem_rsp.rdata = rdata_reg;

  // ----------------------------------------------------------------------
  // Decode and response mux
  // ----------------------------------------------------------------------
  always_comb begin : decode
    ram_req.core.cs         = 1'b0;
    ram_req.core.we         = mem_req.wstrb;
    ram_req.core.address    = mem_req.addr.mem.word[7:0];
    ram_req.core.write_data = mem_req.wdata;
    ram_req.word            = mem_req.addr.mem.word[`RAM_ADDR_BITS-1:0];

    // MMIO cores see a single write enable
    timer_req.cs         = 1'b0;
    timer_req.we         = {4{|mem_req.wstrb}};
    timer_req.address    = mem_req.addr.mmio.offset[9:2];
    timer_req.write_data = mem_req.wdata;
    ctrl_req             = timer_req;

    rdata_new = 32'h0;
    ready_new = 1'b0;

    if (access) begin
      if (force_trap) begin
        rdata_new = `ILLEGAL_INSTRUCTION;
        ready_new = 1'b1;
      end else begin
        case (core_pkg::area_e'(mem_req.addr.mem.area))
          core_pkg::AREA_RAM: begin
            ram_req.core.cs = 1'b1;
            rdata_new       = ram_rsp.read_data;
            ready_new       = ram_rsp.ready;
          end
          core_pkg::AREA_MMIO: begin
            case (core_pkg::core_e'(mem_req.addr.mmio.core))
              core_pkg::CORE_TIMER: begin
                timer_req.cs = 1'b1;
                rdata_new    = timer_rsp.read_data;
                ready_new    = timer_rsp.ready;
              end
              core_pkg::CORE_CTRL: begin
                ctrl_req.cs = 1'b1;
                rdata_new   = ctrl_rsp.read_data;
                ready_new   = ctrl_rsp.ready;
              end
              // Unmapped core answers zero at once
              default: ready_new = 1'b1;
            endcase
          end
          // ROM and reserved areas read as zero
          core_pkg::AREA_ROM,
          core_pkg::AREA_RESERVED: ready_new = 1'b1;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin : rsp_reg
    if (!reset_n) begin
      rdata_reg <= 32'h0;
      ready_reg <= 1'b0;
    end else begin
      rdata_reg <= rdata_new;
      ready_reg <= ready_new;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  ready_single_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    mem_rsp.ready |=> !mem_rsp.ready);

  one_core_selected: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0({ram_req.core.cs, timer_req.cs, ctrl_req.cs}));

endmodule

// ==== verilog/ram.sv ====
/*
  Byte-writable word RAM with a registered read response
*/
`include "app_soc_defines.svh"

module ram (
  input  logic               clk,
  input  logic               reset_n,
  input  bus_pkg::ram_req_t  req,
  output bus_pkg::core_rsp_t rsp
);

  logic [31:0] mem [0:`RAM_WORDS-1];
  logic [31:0] read_data_reg;
  logic        ready_reg;

  assign rsp.read_data = read_data_reg;
  assign rsp.ready     = ready_reg;

  // Old word is read out, strobed lanes are updated
  always_ff @(posedge clk) begin : mem_access
    if (req.core.cs) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (req.core.we[lane]) begin
          mem[req.word][lane*8 +: 8] <= req.core.write_data[lane*8 +: 8];
        end
      end
      read_data_reg <= mem[req.word];
    end
  end

  always_ff @(posedge clk) begin : ready_update
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= req.core.cs;
    end
  end

endmodule

// ==== verilog/timer.sv ====
/*
  Down-counting timer with prescaler, start/stop control and running status
*/
module timer (
  input  logic               clk,
  input  logic               reset_n,
  input  bus_pkg::core_req_t req,
  output bus_pkg::core_rsp_t rsp
);

  logic [31:0] prescaler_reg;
  logic [31:0] initial_reg;
  logic [31:0] count_reg;
  logic [31:0] prescale_ctr_reg;
  logic        running_reg;
  logic [31:0] read_data_reg;
  logic [31:0] read_data_new;
  logic        ready_reg;
  logic        write;
  logic        start;
  logic        stop;

  assign write = req.cs && |req.we;
  assign start = write && req.address == core_pkg::TIMER_CTRL && req.write_data[0];
  assign stop  = write && req.address == core_pkg::TIMER_CTRL && req.write_data[1];

  assign rsp.read_data = read_data_reg;
  assign rsp.ready     = ready_reg;

  // ----------------------------------------------------------------------
  // Counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin : count_update
    if (!reset_n) begin
      prescaler_reg    <= 32'h0;
      initial_reg      <= 32'h0;
      count_reg        <= 32'h0;
      prescale_ctr_reg <= 32'h0;
      running_reg      <= 1'b0;
    end else begin
      if (write && req.address == core_pkg::TIMER_PRESCALER) begin
        prescaler_reg <= req.write_data;
      end
      if (write && req.address == core_pkg::TIMER_INITIAL) begin
        initial_reg <= req.write_data;
      end

      if (start) begin
        running_reg      <= 1'b1;
        count_reg        <= initial_reg;
        prescale_ctr_reg <= prescaler_reg;
      end else if (stop) begin
        running_reg <= 1'b0;
      end else if (running_reg) begin
        // Done at zero, otherwise one step per PRESCALER+1 cycles
        if (count_reg == 32'h0) begin
          running_reg <= 1'b0;
        end else if (prescale_ctr_reg == 32'h0) begin
          prescale_ctr_reg <= prescaler_reg;
          count_reg        <= count_reg - 32'h1;
        end else begin
          prescale_ctr_reg <= prescale_ctr_reg - 32'h1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Register read
  // ----------------------------------------------------------------------
  always_comb begin : read_mux
    case (req.address)
      core_pkg::TIMER_STATUS:    read_data_new = {31'h0, running_reg};
      core_pkg::TIMER_PRESCALER: read_data_new = prescaler_reg;
      core_pkg::TIMER_INITIAL:   read_data_new = initial_reg;
      core_pkg::TIMER_COUNT:     read_data_new = count_reg;
      default:                   read_data_new = 32'h0;
    endcase
  end

  always_ff @(posedge clk) begin : rsp_update
    read_data_reg <= read_data_new;
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= req.cs;
    end
  end

  // Between reloads the count only moves down, so it cannot wrap
  no_wrap_at_zero: assert property (@(posedge clk) disable iff (!reset_n)
    (running_reg && !start) |=> count_reg <= $past(count_reg));

endmodule

// ==== verilog/ctrl_regs.sv ====
/*
  Control registers: identity, sticky application mode, LEDs, trap request
*/
`include "app_soc_defines.svh"

module ctrl_regs (
  input  logic               clk,
  input  logic               reset_n,
  input  bus_pkg::core_req_t req,
  output bus_pkg::core_rsp_t rsp,
  input  bus_pkg::mem_req_t  mem_req,
  output logic               force_trap,
  output logic               led_r,
  output logic               led_g,
  output logic               led_b
);

  logic        app_mode_reg;
  logic [2:0]  led_reg;
  logic [31:0] read_data_reg;
  logic [31:0] read_data_new;
  logic        ready_reg;
  logic        write;

  assign write = req.cs && |req.we;

  // LED bits ordered r, g, b from the top
  assign led_r = led_reg[2];
  assign led_g = led_reg[1];
  assign led_b = led_reg[0];

  // Applications may not execute from MMIO
  assign force_trap = app_mode_reg && mem_req.valid && mem_req.instr &&
                      mem_req.addr.mem.area == core_pkg::AREA_MMIO;

  assign rsp.read_data = read_data_reg;
  assign rsp.ready     = ready_reg;

  always_ff @(posedge clk) begin : reg_update
    if (!reset_n) begin
      app_mode_reg <= 1'b0;
      led_reg      <= 3'h0;
      ready_reg    <= 1'b0;
    end else begin
      ready_reg <= req.cs;
      // Any write sets app mode, nothing clears it short of reset
      if (write && req.address == core_pkg::CTRL_APP_MODE) begin
        app_mode_reg <= 1'b1;
      end
      if (write && req.address == core_pkg::CTRL_LED) begin
        led_reg <= req.write_data[2:0];
      end
    end
  end

  always_comb begin : read_mux
    case (req.address)
      core_pkg::CTRL_NAME:     read_data_new = `CTRL_NAME0;
      core_pkg::CTRL_APP_MODE: read_data_new = {31'h0, app_mode_reg};
      core_pkg::CTRL_LED:      read_data_new = {29'h0, led_reg};
      default:                 read_data_new = 32'h0;
    endcase
  end

  always_ff @(posedge clk) begin : read_update
    read_data_reg <= read_data_new;
  end

endmodule

// ==== verilog/app_soc.sv ====
/*
  Memory subsystem top: decoder, RAM, timer and control registers
*/
module app_soc (
  input  logic              clk,
  input  logic              reset_n,
  input  bus_pkg::mem_req_t mem_req,
  output bus_pkg::mem_rsp_t mem_rsp,
  output logic              led_r,
  output logic              led_g,
  output logic              led_b
);

  bus_pkg::ram_req_t  ram_req;
  bus_pkg::core_req_t timer_req;
  bus_pkg::core_req_t ctrl_req;
  bus_pkg::core_rsp_t ram_rsp;
  bus_pkg::core_rsp_t timer_rsp;
  bus_pkg::core_rsp_t ctrl_rsp;
  logic               force_trap;

  mem_decoder decoder_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .force_trap (force_trap),
    .ram_req    (ram_req),
    .timer_req  (timer_req),
    .ctrl_req   (ctrl_req),
    .ram_rsp    (ram_rsp),
    .timer_rsp  (timer_rsp),
    .ctrl_rsp   (ctrl_rsp)
  );

  ram ram_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (ram_req),
    .rsp     (ram_rsp)
  );

  timer timer_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (timer_req),
    .rsp     (timer_rsp)
  );

  // Watches the raw master request to spot MMIO fetches
  ctrl_regs ctrl_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .req        (ctrl_req),
    .rsp        (ctrl_rsp),
    .mem_req    (mem_req),
    .force_trap (force_trap),
    .led_r      (led_r),
    .led_g      (led_g),
    .led_b      (led_b)
  );

endmodule

// ==== verification/tb_clock.sv ====
/*
  Testbench clock source, period of 40 time units
*/
module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

endmodule

// ==== verification/tb_app_soc.sv ====
/*
  Testbench for app_soc: runs the transactions of the input file against
  the DUT and checks read data, LEDs and the RAM byte merge
*/
`include "app_soc_defines.svh"

module tb_app_soc;

  localparam int MAX_LINES     = 64;
  localparam int FIELDS        = 6;
  localparam int READY_TIMEOUT = 20;
  localparam int POLL_LIMIT    = 200;

  logic              clk;
  logic              reset_n;
  bus_pkg::mem_req_t mem_req;
  bus_pkg::mem_rsp_t mem_rsp;
  logic              led_r;
  logic              led_g;
  logic              led_b;

  // Six words per line: op, addr, wdata, wstrb, instr, expected
  logic [31:0] stim [0:MAX_LINES*FIELDS-1];
  logic [31:0] ram_model [0:`RAM_WORDS-1];
  int          errors;
  int          tests_run;

  tb_clock clock_gen (
    .clk (clk)
  );

  app_soc dut0 (
    .clk     (clk),
    .reset_n (reset_n),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .led_r   (led_r),
    .led_g   (led_g),
    .led_b   (led_b)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Strobed lanes take the new byte, the rest keep the old one
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (strb[lane]) begin
        result[lane*8 +: 8] = new_word[lane*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("Fail at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // One request, held until ready, then valid drops on the next edge
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input logic instr,
                            output logic [31:0] rdata);
    bus_pkg::mem_req_t req;
    int                cycles;
    logic              got;
    req       = '0;
    req.valid = 1'b1;
    req.instr = instr;
    req.addr  = addr;
    req.wdata = wdata;
    req.wstrb = wstrb;
    cycles    = 0;
    got       = 1'b0;
    rdata     = 32'h0;
    @(posedge clk);
    mem_req <= req;
    while (!got && cycles < READY_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (mem_rsp.ready) begin
        got   = 1'b1;
        rdata = mem_rsp.rdata;
      end
    end
    @(posedge clk);
    mem_req <= '0;
    assert (got) else begin
      $display("No ready within %0d cycles for address %h", READY_TIMEOUT, addr);
      errors++;
    end
  endtask

  task automatic check_idle_after_reset();
    repeat (3) begin
      @(negedge clk);
      check_value("mem_rsp.ready", 32'h0, {31'h0, mem_rsp.ready});
      check_value("mem_rsp.rdata", 32'h0, mem_rsp.rdata);
      check_value("led_rgb", 32'h0, {29'h0, led_r, led_g, led_b});
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin : main
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] wstrb;
    logic [31:0] instr;
    logic [31:0] expected;
    logic [31:0] rdata;
    logic [31:0] word_data;
    int          line;
    int          errors_before;
    int          polls;

    mem_req   = '0;
    reset_n   = 1'b0;
    errors    = 0;
    tests_run = 0;
    void'($urandom(32'h3840634f));
    for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
      stim[i] = 32'hffff_ffff;
    end
    $readmemh("verification/app_soc_input.txt", stim);

    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    errors_before = errors;
    check_idle_after_reset();
    tests_run++;
    $display("test 0: idle after reset %s", errors == errors_before ? "ok" : "mismatch");

    line = 0;
    while (line < MAX_LINES && stim[line*FIELDS] != 32'hffff_ffff) begin
      op            = stim[line*FIELDS];
      addr          = stim[line*FIELDS + 1];
      wdata         = stim[line*FIELDS + 2];
      wstrb         = stim[line*FIELDS + 3];
      instr         = stim[line*FIELDS + 4];
      expected      = stim[line*FIELDS + 5];
      errors_before = errors;
      case (op)
        32'h0: bus_access(addr, wdata, wstrb[3:0], instr[0], rdata);
        32'h1: begin
          bus_access(addr, 32'h0, 4'h0, instr[0], rdata);
          check_value("mem_rsp.rdata", expected, rdata);
        end
        32'h2: begin
          bus_access(addr, wdata, wstrb[3:0], instr[0], rdata);
          @(negedge clk);
          check_value("led_rgb", expected, {29'h0, led_r, led_g, led_b});
        end
        32'h3: begin
          polls = 0;
          rdata = ~expected;
          while (rdata != expected && polls < POLL_LIMIT) begin
            bus_access(addr, 32'h0, 4'h0, instr[0], rdata);
            polls++;
          end
          assert (rdata == expected) else begin
            $display("Address %h never read %h within %0d polls", addr, expected, POLL_LIMIT);
            errors++;
          end
        end
        32'h4: begin
          word_data = $urandom;
          ram_model[addr[11:2]] = merge_bytes(ram_model[addr[11:2]], word_data, wstrb[3:0]);
          bus_access(addr, word_data, wstrb[3:0], instr[0], rdata);
        end
        32'h5: begin
          bus_access(addr, 32'h0, 4'h0, instr[0], rdata);
          check_value("mem_rsp.rdata", ram_model[addr[11:2]], rdata);
        end
        default: begin
          $display("Unknown operation %h on input line %0d", op, line + 1);
          errors++;
        end
      endcase
      tests_run++;
      line++;
      $display("test %0d: op %0d addr %h %s", line, op, addr,
               errors == errors_before ? "ok" : "mismatch");
    end

    if (line == 0) begin
      $display("No transactions were read from the input file");
      errors++;
    end

    $display("tests run %0d, checks failed %0d", tests_run, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== app_soc.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/core_pkg.sv
verilog/mem_decoder.sv
verilog/ram.sv
verilog/timer.sv
verilog/ctrl_regs.sv
verilog/app_soc.sv
verification/tb_clock.sv
verification/tb_app_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the app_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f app_soc.f --top-module tb_app_soc -o tb_app_soc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_app_soc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== verification/app_soc_input.txt ====
// op addr wdata wstrb instr expected
// op 0 write, 1 read+compare, 2 write+LED check, 3 poll, 4 RAM random write, 5 RAM read
1 C1000024 0 0 0 0
1 FF000020 0 0 0 0
1 FF000024 0 0 0 0
4 40000000 0 f 0 0
4 40000004 0 f 0 0
4 40000ffc 0 f 0 0
4 40000000 0 3 0 0
4 40000004 0 c 0 0
4 40000ffc 0 5 0 0
5 40000000 0 0 0 0
5 40000004 0 0 1 0
5 40000ffc 0 0 0 0
1 00000100 0 0 0 0
1 80000040 0 0 0 0
1 C2000000 0 0 0 0
1 FF000000 0 0 0 6170705f
1 FF000000 0 0 1 6170705f
2 FF000024 5 f 0 5
2 FF000024 2 1 0 2
0 FF000020 a5 f 0 0
1 FF000020 0 0 0 1
0 FF000020 0 f 0 0
1 FF000020 0 0 0 1
1 FF000000 0 0 1 0
1 FF000000 0 0 0 6170705f
1 FF000024 0 0 1 0
1 FF000024 0 0 0 2
0 C1000028 3 f 0 0
0 C100002c 14 f 0 0
0 C1000020 1 f 0 0
1 C1000024 0 0 0 1
3 C1000024 0 0 0 0
1 C1000030 0 0 0 0
